//--- maPipe_config.svh
/* Sizes and latencies of the multiply-add lane
   DEPTH_MLT and DEPTH_ADD are also the upstream credit counts per class */
`ifndef MA_PIPE_CONFIG_SVH
`define MA_PIPE_CONFIG_SVH

// Buffer depths and credit pools
`define DEPTH_MLT	4
`define DEPTH_ADD	4
`define ADD_ENTRIES	(`DEPTH_ADD + `DEPTH_MLT)	// Room for every chained token

// Stage latencies in cycles
`define MLT_LATENCY	3
`define ADD_LATENCY	2

// Field widths
`define DATA_WIDTH	16
`define TAG_WIDTH	5
`define ISSUE_WIDTH	6

`endif

//--- tokenPkg.sv
/* Token layout shared by the stages and the token pipe
   The 4-bit operation word reads differently for each class */
`default_nettype none
`include "maPipe_config.svh"

package tokenPkg;

	localparam logic OP_MLT = 1'b1;
	localparam logic OP_ADD = 1'b0;

	typedef logic [`DATA_WIDTH-1:0] data_t;
	typedef logic [`TAG_WIDTH-1:0] tag_t;
	typedef logic [`ISSUE_WIDTH-1:0] issueNo_t;	// Wraps, compared by difference

	typedef struct packed {
		logic opClass;
		logic chainAdd;	// Finish as a*b+c in the adder
		logic [1:0] spare;
	} mltView_t;

	typedef struct packed {
		logic opClass;
		logic subtract;
		logic [1:0] spare;
	} addView_t;

	typedef union packed {
		mltView_t mlt;
		addView_t add;
	} opWord_u;

	typedef struct packed {
		logic valid;
		logic fromMlt;	// Origin class for the credit return
		tag_t tag;
		issueNo_t issueNo;
		opWord_u opWord;
		data_t a;
		data_t b;
		data_t c;
		data_t result;
	} token_t;

	typedef struct packed {
		logic valid;
		tag_t tag;
		data_t result;
	} commit_t;

endpackage

`default_nettype wire

//--- flowPkg.sv
/* Credit handshake types between the lane and upstream
   A credit pulse lasts one cycle and returns exactly one credit */
`default_nettype none
`include "maPipe_config.svh"

package flowPkg;

	// Largest pool decides the counter width
	localparam int CREDIT_MAX = (`DEPTH_MLT > `DEPTH_ADD) ? `DEPTH_MLT : `DEPTH_ADD;

	typedef struct packed {
		logic mlt;	// Multiply credit back
		logic add;	// Add credit back
	} creditRet_t;

	typedef logic [$clog2(CREDIT_MAX + 1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- ringBuffCtrl.sv
/* Pointer control for one ring buffer, no overflow protection inside
   Caller must not write when full nor read when empty */
`timescale 1ns/10ps
`default_nettype none

module ringBuffCtrl #(
	parameter int numEntry = 4,
	localparam int addrWidth = $clog2(numEntry)
)(
	input wire clock,
	input wire reset,
	input wire we,
	input wire re,
	output logic [addrWidth-1:0] wAddr,
	output logic [addrWidth-1:0] rAddr,
	output logic full,
	output logic empty,
	output logic [addrWidth:0] num
);

	// Wrap for depths that are not a power of two
	function automatic logic [addrWidth-1:0] nextPtr(input logic [addrWidth-1:0] ptr);
		if (ptr == addrWidth'(numEntry - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			wAddr <= '0;
			rAddr <= '0;
			num <= '0;
		end else begin
			if (we) wAddr <= nextPtr(wAddr);
			if (re) rAddr <= nextPtr(rAddr);
			if (we && !re) num <= num + 1'b1;
			else if (re && !we) num <= num - 1'b1;	// Both at once keeps the count
		end
	end

	assign full = (num == (addrWidth + 1)'(numEntry));
	assign empty = (num == '0);

endmodule

`default_nettype wire

//--- mulStage.sv
/* Multiplier with MLT_LATENCY cycles and no stall
   Only the low DATA_WIDTH bits of the product are kept */
`timescale 1ns/10ps
`default_nettype none
`include "maPipe_config.svh"

module mulStage
	import tokenPkg::*;
(
	input wire clock,
	input wire reset,
	input wire token_t inToken,
	output token_t outToken
);

	token_t pipe [`MLT_LATENCY];
	token_t firstIn;
	logic [2*`DATA_WIDTH-1:0] fullProd;

	// Product formed ahead of the first register
	always_comb begin
		fullProd = inToken.a * inToken.b;
		firstIn = inToken;
		firstIn.result = fullProd[`DATA_WIDTH-1:0];
	end

	always_ff @(posedge clock) begin
		pipe[0] <= firstIn;
		for (int i = 1; i < `MLT_LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
		if (reset) begin
			for (int i = 0; i < `MLT_LATENCY; i++) begin
				pipe[i].valid <= 1'b0;	// Payload left as is
			end
		end
	end

	assign outToken = pipe[`MLT_LATENCY-1];

endmodule

`default_nettype wire

//--- addStage.sv
/* Adder and subtractor with ADD_LATENCY cycles and no stall
   Results wrap at DATA_WIDTH bits */
`timescale 1ns/10ps
`default_nettype none
`include "maPipe_config.svh"

module addStage
	import tokenPkg::*;
(
	input wire clock,
	input wire reset,
	input wire token_t inToken,
	output token_t outToken
);

	token_t pipe [`ADD_LATENCY];
	token_t firstIn;

	// Sum or difference set up before the first register
	always_comb begin
		firstIn = inToken;
		if (inToken.opWord.add.subtract) begin
			firstIn.result = inToken.a - inToken.b;
		end else begin
			firstIn.result = inToken.a + inToken.b;
		end
	end

	always_ff @(posedge clock) begin
		pipe[0] <= firstIn;
		for (int i = 1; i < `ADD_LATENCY; i++) begin
			pipe[i] <= pipe[i-1];
		end
		if (reset) begin
			for (int i = 0; i < `ADD_LATENCY; i++) begin
				pipe[i].valid <= 1'b0;
			end
		end
	end

	assign outToken = pipe[`ADD_LATENCY-1];

endmodule

`default_nettype wire

//--- tokenPipeMa.sv
/* Buffer writes rely on upstream credits, a full buffer drops the write
   Chained tokens need gaps between incoming add tokens to leave */
`timescale 1ns/10ps
`default_nettype none
`include "maPipe_config.svh"

module tokenPipeMa
	import tokenPkg::*;
(
	input wire clock,
	input wire reset,
	input wire token_t inToken,
	output token_t mulIn,
	input wire token_t mulOut,
	output token_t addIn,
	input wire token_t addOut,
	input wire grant,
	output commit_t commitOut,
	output logic commitMlt,
	output logic commitAdd
);

	localparam int mltAddrWidth = $clog2(`DEPTH_MLT);
	localparam int addAddrWidth = $clog2(`ADD_ENTRIES);

	logic mltWe, mltRe, mltFull, mltEmpty;
	logic [mltAddrWidth-1:0] mltWAddr, mltRAddr;
	logic addWe, addRe, addFull, addEmpty;
	logic [addAddrWidth-1:0] addWAddr, addRAddr;

	token_t mltBuf [`DEPTH_MLT];
	token_t addBuf [`ADD_ENTRIES];
	token_t mltHead, addHead, selHead;
	token_t stamped, chainTok;

	issueNo_t issueCnt;
	issueNo_t mltAge, addAge;
	logic isMulIn, isAddIn, chainGo;
	logic mltReady, addReady, selMlt, fire;

	////////////////////////////////////////////////////////////
	// Issue stamping and steering

	always_ff @(posedge clock) begin
		if (reset) issueCnt <= '0;
		else if (inToken.valid) issueCnt <= issueCnt + 1'b1;
	end

	assign isMulIn = inToken.valid && (inToken.opWord.mlt.opClass == OP_MLT);
	assign isAddIn = inToken.valid && (inToken.opWord.add.opClass == OP_ADD);

	always_comb begin
		stamped = inToken;
		stamped.issueNo = issueCnt;
		stamped.fromMlt = (inToken.opWord.mlt.opClass == OP_MLT);
	end

	// Multiply head rewritten as c + product
	always_comb begin
		chainTok = mltHead;
		chainTok.a = mltHead.result;
		chainTok.b = mltHead.c;
		chainTok.opWord.add.opClass = OP_ADD;
		chainTok.opWord.add.subtract = 1'b0;
		chainTok.fromMlt = 1'b1;
	end

	assign chainGo = !mltEmpty && mltHead.opWord.mlt.chainAdd && !isAddIn;

	always_comb begin
		mulIn = stamped;
		mulIn.valid = isMulIn;
		if (isAddIn) begin
			addIn = stamped;
			addIn.valid = 1'b1;
		end else begin
			addIn = chainTok;	// Fills the empty adder slot
			addIn.valid = chainGo;
		end
	end

	////////////////////////////////////////////////////////////
	// Token buffers, payload only

	assign mltWe = mulOut.valid && !mltFull;
	assign addWe = addOut.valid && !addFull;

	always_ff @(posedge clock) begin
		if (mltWe) mltBuf[mltWAddr] <= mulOut;
		if (addWe) addBuf[addWAddr] <= addOut;
	end

	assign mltHead = mltBuf[mltRAddr];
	assign addHead = addBuf[addRAddr];

	////////////////////////////////////////////////////////////
	// Oldest-first commit

	assign mltReady = !mltEmpty && !mltHead.opWord.mlt.chainAdd;
	assign addReady = !addEmpty;

	// Larger distance from the counter means issued earlier
	assign mltAge = issueCnt - mltHead.issueNo;
	assign addAge = issueCnt - addHead.issueNo;
	assign selMlt = mltReady && (!addReady || (mltAge > addAge));
	assign selHead = selMlt ? mltHead : addHead;

	always_comb begin
		commitOut = '0;
		if (mltReady || addReady) begin
			commitOut.valid = 1'b1;
			commitOut.tag = selHead.tag;
			commitOut.result = selHead.result;
		end
	end

	assign fire = commitOut.valid && grant;
	assign mltRe = chainGo || (fire && selMlt);	// Never both in one cycle
	assign addRe = fire && !selMlt;
	assign commitMlt = fire && selHead.fromMlt;
	assign commitAdd = fire && !selHead.fromMlt;

	ringBuffCtrl #(
		.numEntry(`DEPTH_MLT)
	) mltCtrl (
		.clock(clock),
		.reset(reset),
		.we(mltWe),
		.re(mltRe),
		.wAddr(mltWAddr),
		.rAddr(mltRAddr),
		.full(mltFull),
		.empty(mltEmpty),
		.num()
	);

	ringBuffCtrl #(
		.numEntry(`ADD_ENTRIES)
	) addCtrl (
		.clock(clock),
		.reset(reset),
		.we(addWe),
		.re(addRe),
		.wAddr(addWAddr),
		.rAddr(addRAddr),
		.full(addFull),
		.empty(addEmpty),
		.num()
	);

endmodule

`default_nettype wire

//--- maPipeTop.sv
/* Multiply-add lane with per-class credits, upstream sends only with credit
   Credit pulses lag the commit edge by one cycle */
`timescale 1ns/10ps
`default_nettype none

module maPipeTop
	import tokenPkg::*;
	import flowPkg::*;
(
	input wire clock,
	input wire reset,
	input wire token_t inToken,
	input wire grant,
	output commit_t commitOut,
	output creditRet_t creditRet
);

	token_t mulIn, mulOut;
	token_t addIn, addOut;
	logic commitMlt, commitAdd;

	tokenPipeMa pipeCtrl (
		.clock(clock),
		.reset(reset),
		.inToken(inToken),
		.mulIn(mulIn),
		.mulOut(mulOut),
		.addIn(addIn),
		.addOut(addOut),
		.grant(grant),
		.commitOut(commitOut),
		.commitMlt(commitMlt),
		.commitAdd(commitAdd)
	);

	mulStage mulUnit (
		.clock(clock),
		.reset(reset),
		.inToken(mulIn),
		.outToken(mulOut)
	);

	addStage addUnit (
		.clock(clock),
		.reset(reset),
		.inToken(addIn),
		.outToken(addOut)
	);

	// Credit class follows the token origin
	always_ff @(posedge clock) begin
		if (reset) begin
			creditRet <= '0;
		end else begin
			creditRet.mlt <= commitMlt;
			creditRet.add <= commitAdd;
		end
	end

endmodule

`default_nettype wire

//--- maPipe_chk.sv
/* Port-level assertions on credit return and commit of the lane top
   Buffer contents and result values are not covered here */
`timescale 1ns/10ps
`default_nettype none

module maPipeChk
	import tokenPkg::*;
	import flowPkg::*;
(
	input wire clock,
	input wire reset,
	input wire grant,
	input wire commit_t commitOut,
	input wire creditRet_t creditRet
);

	// Every pulse traces back to a granted commit one edge earlier
	creditNeedsCommit: assert property (@(posedge clock) disable iff (reset)
		(creditRet.mlt || creditRet.add) |-> $past(commitOut.valid && grant))
		else $error("credit pulse without a commit on the previous edge");

	// Nothing offered and nothing returned once reset has been seen
	quietAfterReset: assert property (@(posedge clock)
		reset |=> (!commitOut.valid && !creditRet.mlt && !creditRet.add))
		else $error("commit or credit active during reset");

	// A granted commit gives back exactly one credit one edge later
	oneCreditPerCommit: assert property (@(posedge clock) disable iff (reset)
		(commitOut.valid && grant) |=> (creditRet.mlt != creditRet.add))
		else $error("granted commit did not return exactly one credit");

endmodule

`default_nettype wire

//--- maPipeTb.sv
/* Table-driven test of the lane with an upstream model that obeys the credit pools
   Tags are row numbers, so the table is limited to 32 rows */
`timescale 1ns/10ps
`default_nettype none
`include "maPipe_config.svh"

module maPipeTb
	import tokenPkg::*;
	import flowPkg::*;
();

	localparam int PERIOD = 40;
	localparam int NUM_ROWS = 20;
	localparam int HOLD_ROW = 8;	// Grant held low starting at this row
	localparam int HOLD_CYCLES = 24;
	localparam int IDLE_CYCLES = `MLT_LATENCY + `ADD_LATENCY + 2;
	localparam int WATCHDOG_CYCLES = 10 + NUM_ROWS * 40;

	typedef struct packed {
		logic isMlt;
		logic flag;	// Chain for multiply rows, subtract for add rows
		data_t a;
		data_t b;
		data_t c;
	} row_t;

	logic clock, reset, grant;
	token_t inToken;
	commit_t commitOut;
	creditRet_t creditRet, expRet;
	credit_t mltCredits, addCredits;
	row_t rows [NUM_ROWS];
	data_t expResult [NUM_ROWS];
	logic [NUM_ROWS-1:0] seen;
	int commitCount, holdLeft;

	maPipeTop i_dut (
		.clock(clock),
		.reset(reset),
		.inToken(inToken),
		.grant(grant),
		.commitOut(commitOut),
		.creditRet(creditRet)
	);

	bind maPipeTop maPipeChk portChecks (
		.clock(clock),
		.reset(reset),
		.grant(grant),
		.commitOut(commitOut),
		.creditRet(creditRet)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Watchdog expired before every token committed");
		$display("TEST FAIL");
		$fatal(1, "Run stopped by watchdog");
	end

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("TEST FAIL");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Reference result of one row from the arithmetic of its class
	function automatic data_t computeExpected(input row_t r);
		logic [31:0] wide;
		if (r.isMlt) begin
			wide = {16'b0, r.a} * {16'b0, r.b};
			if (r.flag) wide = {16'b0, wide[15:0]} + {16'b0, r.c};
		end else if (r.flag) begin
			wide = {16'b0, r.a} - {16'b0, r.b};
		end else begin
			wide = {16'b0, r.a} + {16'b0, r.b};
		end
		return wide[15:0];
	endfunction

	task automatic loadTable();
		rows[0] = '{1'b1, 1'b0, 16'h0003, 16'h0005, 16'h0000};
		rows[1] = '{1'b0, 1'b0, 16'h1234, 16'h0101, 16'h0000};
		rows[2] = '{1'b1, 1'b1, 16'h0010, 16'h0010, 16'h0007};
		rows[3] = '{1'b0, 1'b1, 16'h0005, 16'h0009, 16'h0000};	// Wraps below zero
		rows[4] = '{1'b1, 1'b0, 16'hFFFF, 16'hFFFF, 16'h0000};
		rows[5] = '{1'b1, 1'b1, 16'h0100, 16'h0100, 16'hFFFF};
		rows[6] = '{1'b0, 1'b0, 16'hFFFF, 16'h0002, 16'h0000};
		rows[7] = '{1'b0, 1'b1, 16'h8000, 16'h0001, 16'h0000};
		rows[8] = '{1'b1, 1'b0, 16'h1234, 16'h5678, 16'h0000};
		rows[9] = '{1'b1, 1'b1, 16'h0002, 16'h0003, 16'h0004};
		rows[10] = '{1'b0, 1'b0, 16'h0000, 16'h0000, 16'h0000};
		rows[11] = '{1'b1, 1'b1, 16'h00FF, 16'h00FF, 16'h1111};
		rows[12] = '{1'b0, 1'b1, 16'hABCD, 16'h1234, 16'h0000};
		rows[13] = '{1'b1, 1'b0, 16'h8001, 16'h0002, 16'h0000};
		rows[14] = '{1'b0, 1'b0, 16'h7FFF, 16'h0001, 16'h0000};
		rows[15] = '{1'b1, 1'b1, 16'h0007, 16'h0009, 16'hFFF0};
		rows[16] = '{1'b0, 1'b1, 16'h0000, 16'h0001, 16'h0000};
		rows[17] = '{1'b1, 1'b0, 16'h0000, 16'hBEEF, 16'h0000};
		rows[18] = '{1'b0, 1'b0, 16'hCAFE, 16'h1111, 16'h0000};
		rows[19] = '{1'b1, 1'b1, 16'h1001, 16'h0010, 16'h0100};
		for (int i = 0; i < NUM_ROWS; i++) begin
			expResult[i] = computeExpected(rows[i]);
		end
	endtask

	////////////////////////////////////////////////////////////
	// One falling edge of upstream and downstream bookkeeping

	task automatic tick();
		tag_t tagSeen;
		@(negedge clock);
		inToken = '0;
		checkValue("creditRet", {30'b0, expRet}, {30'b0, creditRet});
		if (creditRet.mlt) mltCredits++;
		if (creditRet.add) addCredits++;
		checkValue("mlt credit bound", 1, mltCredits <= `DEPTH_MLT);
		checkValue("add credit bound", 1, addCredits <= `DEPTH_ADD);
		if (holdLeft > 0) begin
			grant = 1'b0;
			if (holdLeft == 1) checkValue("commitOut.valid under hold", 1, commitOut.valid);
			holdLeft--;
		end else begin
			grant = ($urandom % 4) != 0;
		end
		expRet = '0;
		if (commitOut.valid && grant) begin	// Leaves on the next rising edge
			tagSeen = commitOut.tag;
			checkValue("commitOut.tag in range", 1, tagSeen < NUM_ROWS);
			checkValue("tag commit count", 0, seen[tagSeen]);
			checkValue("commitOut.result", expResult[tagSeen], commitOut.result);
			seen[tagSeen] = 1'b1;
			commitCount++;
			expRet.mlt = rows[tagSeen].isMlt;	// Chained rows return a multiply credit
			expRet.add = !rows[tagSeen].isMlt;
		end
	endtask

	function automatic logic hasCredit(input int row);
		return rows[row].isMlt ? (mltCredits != 0) : (addCredits != 0);
	endfunction

	initial begin
		int gap;
		token_t t;
		void'($urandom(40));
		reset = 1'b1;
		grant = 1'b0;
		inToken = '0;
		expRet = '0;
		mltCredits = `DEPTH_MLT;
		addCredits = `DEPTH_ADD;
		seen = '0;
		commitCount = 0;
		holdLeft = 0;
		loadTable();
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		checkValue("commitOut.valid after reset", 0, commitOut.valid);
		checkValue("creditRet after reset", 0, {30'b0, creditRet});

		for (int i = 0; i < NUM_ROWS; i++) begin
			gap = $urandom % 3;
			if (i == HOLD_ROW) holdLeft = HOLD_CYCLES;
			repeat (gap) tick();
			tick();
			while (!hasCredit(i)) tick();
			t = '0;
			t.valid = 1'b1;
			t.tag = tag_t'(i);
			t.opWord.mlt.opClass = rows[i].isMlt ? OP_MLT : OP_ADD;
			if (rows[i].isMlt) t.opWord.mlt.chainAdd = rows[i].flag;
			else t.opWord.add.subtract = rows[i].flag;
			t.a = rows[i].a;
			t.b = rows[i].b;
			t.c = rows[i].c;
			inToken = t;
			if (rows[i].isMlt) mltCredits--;
			else addCredits--;
		end

		// Drain and then watch the idle lane for stray commits
		while (commitCount < NUM_ROWS) tick();
		repeat (IDLE_CYCLES) begin
			tick();
			checkValue("commitOut.valid after drain", 0, commitOut.valid);
		end
		checkValue("mlt credits at end", `DEPTH_MLT, mltCredits);
		checkValue("add credits at end", `DEPTH_ADD, addCredits);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- maPipe.f
+incdir+.
tokenPkg.sv
flowPkg.sv
ringBuffCtrl.sv
mulStage.sv
addStage.sv
tokenPipeMa.sv
maPipeTop.sv
maPipe_chk.sv
maPipeTb.sv

//--- Makefile
# Verilator build and run of the multiply-add lane
# Override any variable on the command line, e.g. make run OBJDIR=build

VERILATOR ?= verilator
TOP ?= maPipeTb
FILELIST ?= maPipe.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
BIN = $(OBJDIR)/V$(TOP)
SOURCES = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
